// File: rtl/fir_pkg.sv
`default_nettype none

package fir_pkg;

  localparam int SAMPLE_W = 16;                 // Signed sample width
  localparam int COEF_W   = 18;                 // Coefficient width to match the DSP B port
  localparam int ACC_W    = 48;                 // Post-adder and accumulator width
  localparam int NLANES   = 4;                  // Samples carried per stream word
  localparam int NCOEF    = 4;                  // Distinct taps of the symmetric 7-tap filter
  localparam int WORD_W   = NLANES * SAMPLE_W;  // Stream word width

  localparam int OUT_LSB  = 16;                 // Lowest accumulator bit sent to the output

  typedef logic signed [SAMPLE_W-1:0] sample_t; // One signed sample
  typedef logic signed [COEF_W-1:0]   coef_t;   // One signed coefficient
  typedef logic signed [ACC_W-1:0]    acc_t;    // Tap result
  typedef logic        [WORD_W-1:0]   word_t;   // Lane 0 in the low bits

  // Gain of 1.0 once bits 31:16 are taken
  localparam coef_t COEF_UNITY = 18'h10000;

endpackage

`default_nettype wire

// File: rtl/fir_csr_pkg.sv
`default_nettype none

package fir_csr_pkg;

  localparam int REG_ADDR_W = 4;                  // Register index width
  localparam int REG_DATA_W = 32;                 // Host data width

  typedef logic [REG_ADDR_W-1:0] reg_addr_t;      // Register index
  typedef logic [REG_DATA_W-1:0] reg_data_t;      // Register data

  localparam reg_addr_t REG_ID        = 4'd0;     // Read-only ID
  localparam reg_addr_t REG_CTRLSTAT  = 4'd1;     // ACTIVE and UPDATE
  localparam reg_addr_t REG_COEF_BASE = 4'd2;     // Coefficients at 2..5

  localparam int CTRL_ACTIVE_BIT = 0;             // Filter on when set
  localparam int CTRL_UPDATE_BIT = 1;             // Write-only commit request

  localparam reg_data_t FIR_ID_VALUE   = 32'h53594D34; // "SYM4"
  localparam reg_data_t UNMAPPED_VALUE = 32'hDEADBEEF; // Any address not decoded

endpackage

`default_nettype wire

// File: rtl/fir_addmul.sv
`timescale 1ns/1ns
`default_nettype none

// Pre-add, multiply, post-add tap laid out like a DSP slice
module fir_addmul (
  input  logic             clk,
  input  logic             rst_n,
  input  fir_pkg::sample_t a1,
  input  fir_pkg::sample_t a2,
  input  fir_pkg::coef_t   b,
  input  fir_pkg::acc_t    c,
  output fir_pkg::acc_t    result
);
  import fir_pkg::*;

  sample_t                a1_r;   // A port register
  sample_t                a2_r;   // D port register
  coef_t                  b_r;    // B port register
  coef_t                  b_rr;   // B aligned with the pre-adder output
  logic signed [SAMPLE_W:0] ad_r; // Pre-adder keeps the carry bit
  acc_t                   m_r;    // Product register
  acc_t                   c_r;    // C port register

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      a1_r   <= '0;
      a2_r   <= '0;
      b_r    <= '0;
      b_rr   <= '0;
      ad_r   <= '0;
      m_r    <= '0;
      c_r    <= '0;
      result <= '0;
    end else begin
      a1_r   <= a1;                                // Edge t
      a2_r   <= a2;
      b_r    <= b;
      ad_r   <= (SAMPLE_W + 1)'(a1_r) + (SAMPLE_W + 1)'(a2_r); // Edge t+1
      b_rr   <= b_r;
      m_r    <= acc_t'(ad_r) * acc_t'(b_rr);       // Edge t+2, full product fits
      c_r    <= c;                                 // c enters one stage late
      result <= m_r + c_r;                         // Edge t+3, wraps at 48 bits
    end
  end

  // Pipeline flushed by reset, so X can only come in from the operands
  a_result_known : assert property (
    @(posedge clk)
    rst_n && $past(rst_n, 1) && $past(rst_n, 2) && $past(rst_n, 3)
      |-> !$isunknown(result)
  ) else $error("fir_addmul result unknown after reset");

endmodule

`default_nettype wire

// File: rtl/fir_sample_window.sv
`timescale 1ns/1ns
`default_nettype none

// Three words of history so every lane sees +-3 neighbours
module fir_sample_window (
  input  logic           clk,
  input  logic           rst_n,
  input  fir_pkg::word_t in_data,
  output fir_pkg::word_t win_prev,
  output fir_pkg::word_t win_cur,
  output fir_pkg::word_t win_next
);

  // Whole-word shift each clock
  // next holds the newest word and prev the oldest
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      win_next <= '0;                   // Zero history after reset
      win_cur  <= '0;
      win_prev <= '0;
    end else begin
      win_next <= in_data;              // Word k
      win_cur  <= win_next;             // Word k-1 is the one filtered
      win_prev <= win_cur;              // Word k-2 feeds the left taps
    end
  end

endmodule

`default_nettype wire

// File: rtl/fir_csr.sv
`timescale 1ns/1ns
`default_nettype none

// Host registers with shadow and committed coefficient banks
module fir_csr (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   wr_en,
  input  fir_csr_pkg::reg_addr_t wr_addr,
  input  fir_csr_pkg::reg_data_t wr_data,
  input  fir_csr_pkg::reg_addr_t rd_addr,
  output fir_csr_pkg::reg_data_t rd_data,
  output fir_pkg::coef_t         coef0,
  output fir_pkg::coef_t         coef1,
  output fir_pkg::coef_t         coef2,
  output fir_pkg::coef_t         coef3,
  output logic                   active
);
  import fir_pkg::*;
  import fir_csr_pkg::*;

  coef_t shd_coef [NCOEF];   // Host-visible coefficients
  coef_t cmt_coef [NCOEF];   // Values the filter runs with
  logic  shd_active;         // Host-visible ACTIVE
  logic  cmt_active;         // ACTIVE seen by the datapath
  logic  ctrl_wr;            // Write to CTRLSTAT this cycle
  logic  commit_req;         // UPDATE set or ACTIVE toggled
  logic  commit_q;           // Copy shadow to committed next edge

  assign ctrl_wr    = wr_en && (wr_addr == REG_CTRLSTAT);
  assign commit_req = ctrl_wr &&
                      (wr_data[CTRL_UPDATE_BIT] || (wr_data[CTRL_ACTIVE_BIT] != shd_active));

  // Shadow bank follows host writes
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      shd_active <= 1'b0;
      for (int i = 0; i < NCOEF; i++) begin
        shd_coef[i] <= (i == 0) ? COEF_UNITY : '0; // Unity pass with c0 only
      end
    end else if (wr_en) begin
      if (ctrl_wr) begin
        shd_active <= wr_data[CTRL_ACTIVE_BIT];      // UPDATE itself is not stored
      end
      for (int i = 0; i < NCOEF; i++) begin
        if (wr_addr == reg_addr_t'(REG_COEF_BASE + i)) begin
          shd_coef[i] <= coef_t'(wr_data[COEF_W-1:0]); // Upper bits dropped
        end
      end
    end
  end

  // Committed bank lags the commit write by one edge
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      commit_q   <= 1'b0;
      cmt_active <= 1'b0;
      for (int i = 0; i < NCOEF; i++) begin
        cmt_coef[i] <= (i == 0) ? COEF_UNITY : '0;
      end
    end else begin
      commit_q <= commit_req;
      if (commit_q) begin
        cmt_active <= shd_active;                  // Shadow already holds this write
        for (int i = 0; i < NCOEF; i++) begin
          cmt_coef[i] <= shd_coef[i];
        end
      end
    end
  end

  // Read mux from the shadow bank
  always_comb begin
    rd_data = UNMAPPED_VALUE;                      // Default for holes in the map
    if (rd_addr == REG_ID) begin
      rd_data = FIR_ID_VALUE;
    end else if (rd_addr == REG_CTRLSTAT) begin
      rd_data                  = '0;
      rd_data[CTRL_ACTIVE_BIT] = shd_active;       // UPDATE reads as zero
    end else begin
      for (int i = 0; i < NCOEF; i++) begin
        if (rd_addr == reg_addr_t'(REG_COEF_BASE + i)) begin
          rd_data = reg_data_t'(shd_coef[i]);      // Sign-extended from 18 bits
        end
      end
    end
  end

  assign coef0  = cmt_coef[0];
  assign coef1  = cmt_coef[1];
  assign coef2  = cmt_coef[2];
  assign coef3  = cmt_coef[3];
  assign active = cmt_active;

  // Back-to-back commits need a CTRLSTAT write behind each one
  a_commit_pulse : assert property (
    @(posedge clk) disable iff (!rst_n)
    commit_q && $past(commit_q) |-> $past(wr_en, 1) && $past(wr_en, 2)
  ) else $error("fir_csr commit held without a write");

endmodule

`default_nettype wire

// File: rtl/fir_sym_core.sv
`timescale 1ns/1ns
`default_nettype none

// Four lanes of the symmetric 7-tap filter plus a matched bypass
module fir_sym_core (
  input  logic           clk,
  input  logic           rst_n,
  input  fir_pkg::word_t win_prev,
  input  fir_pkg::word_t win_cur,
  input  fir_pkg::word_t win_next,
  input  fir_pkg::coef_t coef0,
  input  fir_pkg::coef_t coef1,
  input  fir_pkg::coef_t coef2,
  input  fir_pkg::coef_t coef3,
  input  logic           active,
  output fir_pkg::word_t out_data
);
  import fir_pkg::*;

  localparam int CTR_DLY    = 3;  // Centre sample waits for the outer taps
  localparam int TAP_REGS   = 4;  // Registers through one fir_addmul
  localparam int SUM_REGS   = 1;  // Outer-tap sum register
  localparam int C_REGS     = 2;  // Centre tap C and P registers
  localparam int BYP_STAGES = 7;  // Bypass delay on win_cur

  sample_t win_s   [3*NLANES];        // prev, cur, next flattened, oldest first
  coef_t   coef_arr [NCOEF];
  acc_t    tap_res [NLANES][NCOEF];   // Index 0 is the centre tap
  acc_t    outer_sum [NLANES];
  acc_t    sum_r   [NLANES];          // Feeds the centre tap c port
  word_t   dly     [BYP_STAGES];      // Shared centre and bypass delay
  sample_t ctr_s   [NLANES];          // x[n] after CTR_DLY edges

  always_comb begin
    for (int i = 0; i < NLANES; i++) begin
      win_s[i]            = win_prev[i*SAMPLE_W +: SAMPLE_W];
      win_s[NLANES + i]   = win_cur[i*SAMPLE_W +: SAMPLE_W];
      win_s[2*NLANES + i] = win_next[i*SAMPLE_W +: SAMPLE_W];
      ctr_s[i]            = dly[CTR_DLY-1][i*SAMPLE_W +: SAMPLE_W];
    end
  end

  assign coef_arr[0] = coef0;
  assign coef_arr[1] = coef1;
  assign coef_arr[2] = coef2;
  assign coef_arr[3] = coef3;

  for (genvar n = 0; n < NLANES; n++) begin : g_lane
    // Outer taps pair x[n+k] with x[n-k]
    for (genvar k = 1; k < NCOEF; k++) begin : g_outer
      fir_addmul u_outer (
        .clk    (clk),
        .rst_n  (rst_n),
        .a1     (win_s[NLANES + n + k]),
        .a2     (win_s[NLANES + n - k]),
        .b      (coef_arr[k]),
        .c      ('0),
        .result (tap_res[n][k])
      );
    end

    // Centre tap adds the outer sum through its c port
    fir_addmul u_centre (
      .clk    (clk),
      .rst_n  (rst_n),
      .a1     (ctr_s[n]),
      .a2     ('0),
      .b      (coef_arr[0]),
      .c      (sum_r[n]),
      .result (tap_res[n][0])
    );
  end

  always_comb begin
    for (int n = 0; n < NLANES; n++) begin
      outer_sum[n] = '0;
      for (int k = 1; k < NCOEF; k++) begin
        outer_sum[n] = outer_sum[n] + tap_res[n][k];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int n = 0; n < NLANES; n++) begin
        sum_r[n] <= '0;
      end
      for (int i = 0; i < BYP_STAGES; i++) begin
        dly[i] <= '0;
      end
      out_data <= '0;
    end else begin
      for (int n = 0; n < NLANES; n++) begin
        sum_r[n] <= outer_sum[n];                     // Edge e+5
      end
      dly[0] <= win_cur;                              // Edge e+1
      for (int i = 1; i < BYP_STAGES; i++) begin
        dly[i] <= dly[i-1];
      end
      for (int n = 0; n < NLANES; n++) begin
        out_data[n*SAMPLE_W +: SAMPLE_W] <= active ?
          tap_res[n][0][OUT_LSB +: SAMPLE_W] :        // Truncated, wraps on overflow
          dly[BYP_STAGES-1][n*SAMPLE_W +: SAMPLE_W];  // Pass-through at equal latency
      end
    end
  end

  // Filter and bypass must reach out_data on the same edge
  a_stage_match : assert property (
    @(posedge clk)
    (BYP_STAGES == CTR_DLY + TAP_REGS) &&
    (BYP_STAGES == TAP_REGS + SUM_REGS + C_REGS)
  ) else $error("fir_sym_core bypass and tap pipeline lengths differ");

endmodule

`default_nettype wire

// File: rtl/fir_sym_top.sv
`timescale 1ns/1ns
`default_nettype none

module fir_sym_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  fir_pkg::word_t         in_data,
  output fir_pkg::word_t         out_data,
  input  logic                   wr_en,
  input  fir_csr_pkg::reg_addr_t wr_addr,
  input  fir_csr_pkg::reg_data_t wr_data,
  input  fir_csr_pkg::reg_addr_t rd_addr,
  output fir_csr_pkg::reg_data_t rd_data
);
  import fir_pkg::*;

  coef_t coef0;      // Committed coefficients
  coef_t coef1;
  coef_t coef2;
  coef_t coef3;
  logic  active;     // Committed ACTIVE
  word_t win_prev;   // Word k-2
  word_t win_cur;    // Word k-1
  word_t win_next;   // Word k

  fir_csr u_csr (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .coef0   (coef0),
    .coef1   (coef1),
    .coef2   (coef2),
    .coef3   (coef3),
    .active  (active)
  );

  fir_sample_window u_window (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_data  (in_data),
    .win_prev (win_prev),
    .win_cur  (win_cur),
    .win_next (win_next)
  );

  fir_sym_core u_core (
    .clk      (clk),
    .rst_n    (rst_n),
    .win_prev (win_prev),
    .win_cur  (win_cur),
    .win_next (win_next),
    .coef0    (coef0),
    .coef1    (coef1),
    .coef2    (coef2),
    .coef3    (coef3),
    .active   (active),
    .out_data (out_data)
  );

endmodule

`default_nettype wire

// File: tb/tb_clkgen.sv
`timescale 1ns/1ns
`default_nettype none

// Free-running clock and a short synchronous reset
module tb_clkgen (
  output logic clk,
  output logic rst_n
);

  localparam int HALF_NS    = 4;  // 8 ns period
  localparam int RST_CYCLES = 2;  // Edges with rst_n low

  initial begin
    clk = 1'b0;
    forever #HALF_NS clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    #1 rst_n = 1'b1;              // Released just after an edge like other inputs
  end

endmodule

`default_nettype wire

// File: tb/fir_sym_tb.sv
`timescale 1ns/1ns
`default_nettype none

module fir_sym_tb;
  import fir_pkg::*;
  import fir_csr_pkg::*;

  localparam int CLK_NS  = 8;
  localparam int LATENCY = 8;    // Edges from window load to out_data
  localparam int SETTLE  = 9;    // Words that mix old and new settings after a commit
  localparam int RUN_LEN = 100;  // Filter words per coefficient set
  localparam int TOTAL_CYCLES = 2 + 40 + 2*60 + 2 + 3*(5 + RUN_LEN) + 96 + 2*(5 + 60) + 12;
  localparam int WATCHDOG_NS  = (TOTAL_CYCLES + 100) * CLK_NS;

  logic      clk;
  logic      rst_n;
  word_t     in_data;
  word_t     out_data;
  logic      wr_en;
  reg_addr_t wr_addr;
  reg_data_t wr_data;
  reg_addr_t rd_addr;
  reg_data_t rd_data;

  word_t m_prev;                 // Model window oldest word
  word_t m_cur;
  word_t m_next;
  coef_t shd_coef [NCOEF];       // Model shadow bank
  coef_t cmt_coef [NCOEF];       // Model committed bank
  logic  shd_active;
  logic  cmt_active;
  logic  commit_pend;            // Copy due on the next edge
  int    edge_cnt;
  int    last_commit_edge;
  word_t exp_q [$];              // Expected out_data, one entry per edge
  int    word_errors;
  int    reg_errors;
  int    x_errors;

  tb_clkgen u_clkgen (.clk(clk), .rst_n(rst_n));

  fir_sym_top dut (
    .clk(clk), .rst_n(rst_n), .in_data(in_data), .out_data(out_data),
    .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
    .rd_addr(rd_addr), .rd_data(rd_data)
  );

  function automatic word_t rand_word();
    return {$urandom, $urandom};
  endfunction

  // Each lane full-scale positive or negative
  function automatic word_t extreme_word();
    word_t w;
    for (int i = 0; i < NLANES; i++) begin
      w[i*SAMPLE_W +: SAMPLE_W] = $urandom_range(1, 0) ? 16'h7FFF : 16'h8000;
    end
    return w;
  endfunction

  // Symmetric sum per lane truncated to bits 31:16 or the centre sample in bypass
  function automatic word_t expected_word();
    word_t   w;
    sample_t s [3*NLANES];
    longint  acc;
    int      c;
    for (int i = 0; i < NLANES; i++) begin
      s[i]            = m_prev[i*SAMPLE_W +: SAMPLE_W];
      s[NLANES + i]   = m_cur[i*SAMPLE_W +: SAMPLE_W];
      s[2*NLANES + i] = m_next[i*SAMPLE_W +: SAMPLE_W];
    end
    for (int n = 0; n < NLANES; n++) begin
      c = NLANES + n;
      acc = longint'(cmt_coef[0]) * longint'(s[c]);
      for (int k = 1; k < NCOEF; k++) begin
        acc = acc + longint'(cmt_coef[k]) * (longint'(s[c+k]) + longint'(s[c-k]));
      end
      w[n*SAMPLE_W +: SAMPLE_W] = cmt_active ? acc[OUT_LSB +: SAMPLE_W] : s[c];
    end
    return w;
  endfunction

  function automatic reg_data_t expected_read(reg_addr_t a);
    int    idx;
    coef_t cv;
    idx = int'(a) - int'(REG_COEF_BASE);
    if (a == REG_ID) return FIR_ID_VALUE;
    if (a == REG_CTRLSTAT) return reg_data_t'(shd_active);
    if (idx < 0 || idx >= NCOEF) return UNMAPPED_VALUE;
    cv = shd_coef[idx];
    return {{(REG_DATA_W - COEF_W){cv[COEF_W-1]}}, cv};  // Sign-extended
  endfunction

  task automatic check_word(input word_t actual, input word_t expected);
    if ($isunknown(actual)) begin
      x_errors++;
      $display("out_data is unknown at %0t ns although reset is over", $time);
    end else if (actual !== expected) begin
      word_errors++;
      $display("FAIL %0t ns: out_data %h, expected %h", $time, actual, expected);
    end
  endtask

  task automatic check_reg(input reg_data_t actual, input reg_data_t expected,
                           input reg_addr_t addr);
    if (actual !== expected) begin
      reg_errors++;
      $display("FAIL %0t ns: rd_data at %0d is %h, expected %h", $time, addr, actual, expected);
    end
  endtask

  // Model of one rising edge from the inputs the DUT just sampled
  task automatic model_edge();
    int a;
    a = int'(wr_addr);
    edge_cnt++;
    if (commit_pend) begin
      cmt_coef         = shd_coef;            // Shadow as it stood before this edge
      cmt_active       = shd_active;
      last_commit_edge = edge_cnt;
    end
    commit_pend = wr_en && (wr_addr == REG_CTRLSTAT) &&
                  (wr_data[CTRL_UPDATE_BIT] || (wr_data[CTRL_ACTIVE_BIT] != shd_active));
    if (wr_en && (wr_addr == REG_CTRLSTAT)) begin
      shd_active = wr_data[CTRL_ACTIVE_BIT];
    end
    if (wr_en && a >= int'(REG_COEF_BASE) && a < int'(REG_COEF_BASE) + NCOEF) begin
      shd_coef[a - int'(REG_COEF_BASE)] = coef_t'(wr_data[COEF_W-1:0]);
    end
    m_prev = m_cur;
    m_cur  = m_next;
    m_next = in_data;
    exp_q.push_back(expected_word());        // Due LATENCY edges from now
  endtask

  task automatic run_cycle(input word_t din, input logic we, input reg_addr_t wa,
                           input reg_data_t wd, input reg_addr_t ra, input logic rchk);
    word_t exp_w;
    @(posedge clk);
    #1;
    model_edge();
    exp_w = exp_q.pop_front();
    if (edge_cnt > last_commit_edge + SETTLE) begin
      check_word(out_data, exp_w);
    end
    in_data = din;
    wr_en   = we;
    wr_addr = wa;
    wr_data = wd;
    rd_addr = ra;
    if (rchk) begin
      #2;                                    // Read mux settles well before the edge
      check_reg(rd_data, expected_read(ra), ra);
    end
  endtask

  // Random words while sweeping every read address
  task automatic stream_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      run_cycle(rand_word(), 1'b0, '0, '0, reg_addr_t'(i), 1'b1);
    end
  endtask

  task automatic write_reg(input reg_addr_t a, input reg_data_t d);
    run_cycle(rand_word(), 1'b1, a, d, a, 1'b1);
  endtask

  task automatic write_ctrl(input logic act, input logic upd);
    reg_data_t d;
    d = '0;
    d[CTRL_ACTIVE_BIT] = act;
    d[CTRL_UPDATE_BIT] = upd;
    write_reg(REG_CTRLSTAT, d);
  endtask

  task automatic load_random_coefs();
    for (int k = 0; k < NCOEF; k++) begin
      write_reg(reg_addr_t'(int'(REG_COEF_BASE) + k), reg_data_t'($urandom));
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: run still going after %0d ns", WATCHDOG_NS);
    $display("test failed");
    $finish;
  end

  initial begin
    reg_addr_t addr;
    coef_t     cx;
    in_data = '0;
    wr_en   = 1'b0;
    wr_addr = '0;
    wr_data = '0;
    rd_addr = '0;
    m_prev  = '0;                            // Zero history after reset
    m_cur   = '0;
    m_next  = '0;
    for (int k = 0; k < NCOEF; k++) begin
      shd_coef[k] = (k == 0) ? 18'h10000 : '0;  // Unity gain on c0
      cmt_coef[k] = shd_coef[k];
    end
    shd_active       = 1'b0;
    cmt_active       = 1'b0;
    commit_pend      = 1'b0;
    edge_cnt         = 0;
    last_commit_edge = -100;
    word_errors      = 0;
    reg_errors       = 0;
    x_errors         = 0;
    void'($urandom(84073));
    repeat (LATENCY) exp_q.push_back('0);    // Pipeline flushed by reset
    wait (rst_n === 1'b1);

    stream_cycles(40);                       // Reset values and bypass
    for (int i = 0; i < 60; i++) begin       // Register map
      addr = reg_addr_t'($urandom);
      write_reg(addr, reg_data_t'($urandom));
      run_cycle(rand_word(), 1'b0, '0, '0, addr, 1'b1);
    end
    write_reg(REG_ID, reg_data_t'($urandom));
    run_cycle(rand_word(), 1'b0, '0, '0, REG_ID, 1'b1);

    for (int r = 0; r < 3; r++) begin        // Filtering with random coefficients
      load_random_coefs();
      write_ctrl(1'b1, 1'b1);
      stream_cycles(RUN_LEN);
    end

    load_random_coefs();                     // Shadow only so the filter keeps the old set
    stream_cycles(30);
    write_ctrl(1'b1, 1'b1);
    stream_cycles(30);
    write_ctrl(1'b0, 1'b0);                  // ACTIVE toggle commits pass-through
    stream_cycles(30);

    for (int r = 0; r < 2; r++) begin        // Full-scale samples and coefficients
      for (int k = 0; k < NCOEF; k++) begin
        cx = ((k + r) % 2 == 0) ? 18'h1FFFF : 18'h20001;  // +-0x1FFFF
        write_reg(reg_addr_t'(int'(REG_COEF_BASE) + k), reg_data_t'(cx));
      end
      write_ctrl(1'b1, 1'b1);
      repeat (60) run_cycle(extreme_word(), 1'b0, '0, '0, REG_CTRLSTAT, 1'b1);
    end
    stream_cycles(12);

    $display("Errors: word %0d, register %0d, unknown %0d", word_errors, reg_errors, x_errors);
    if (word_errors + reg_errors + x_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: fir_sym_top.f
rtl/fir_pkg.sv
rtl/fir_csr_pkg.sv
rtl/fir_addmul.sv
rtl/fir_sample_window.sv
rtl/fir_csr.sv
rtl/fir_sym_core.sv
rtl/fir_sym_top.sv
tb/tb_clkgen.sv
tb/fir_sym_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the FIR testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -sv \
  -f fir_sym_top.f \
  --top-module fir_sym_tb \
  -Mdir obj_dir -o fir_sym_sim

./obj_dir/fir_sym_sim | tee sim.log

if grep -qx "test passed" sim.log; then
  echo "simulation PASS"
  exit 0
else
  echo "simulation FAIL"
  exit 1
fi
